// ==== verilog/uart_defines.svh ====
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// baud timing for the whole subsystem
// one bit lasts UART_OS_DIV * UART_OS_RATE clocks, 64 with the values below

// clock cycles between two oversample ticks
`define UART_OS_DIV 4

// oversample ticks per bit on the line, the rx mid-bit point is half of this
`define UART_OS_RATE 16

// data bits per 8N1 frame, sent and received lsb first
`define UART_DATA_BITS 8

`endif

// ==== verilog/uart_pkg.sv ====
package uart_pkg;

	// transmitter states, same order as the classic four-state tx machine
	typedef enum logic [1:0] {
		TX_IDLE  = 2'b00, // line held high, waiting for a request
		TX_START = 2'b01, // byte captured, start bit goes out on the next bit tick
		TX_DATA  = 2'b10, // data bits shifted out lsb first
		TX_STOP  = 2'b11  // stop bit on the line, done is high here
	} uart_tx_state_t;

	// receiver states
	typedef enum logic [1:0] {
		RX_IDLE  = 2'b00, // hunting for a falling edge on the line
		RX_START = 2'b01, // edge seen, waiting for the middle of the start bit
		RX_DATA  = 2'b10, // sampling data bits in their middle
		RX_STOP  = 2'b11  // waiting for the middle of the stop bit
	} uart_rx_state_t;

	// what the receiver reports for each frame
	typedef struct packed {
		logic [7:0] data;      // received byte
		logic       frame_err; // stop bit was sampled low
	} uart_rx_result_t;

endpackage

// ==== verilog/baud_tick_gen.sv ====
`timescale 1ns/100ps
`include "uart_defines.svh"

module baud_tick_gen (
	input  logic clk_in,
	input  logic arst_n,
	output logic os_tick,
	output logic bit_tick
);

	localparam int DIV_W = (`UART_OS_DIV > 1) ? $clog2(`UART_OS_DIV) : 1; // wide enough for div-1
	localparam int PH_W = $clog2(`UART_OS_RATE); // 4 bits for 16x oversampling
	localparam logic [DIV_W-1:0] DIV_RELOAD = DIV_W'(`UART_OS_DIV - 1); // period of div_cnt is UART_OS_DIV
	localparam logic [PH_W-1:0] PH_LAST = PH_W'(`UART_OS_RATE - 1); // last os tick of a bit

	logic [DIV_W-1:0] div_cnt; // clock down-counter
	logic [PH_W-1:0] os_cnt; // counts os ticks, wraps once per bit
	logic div_zero; // down-counter reached the end of its period

	assign div_zero = (div_cnt == '0);

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= DIV_RELOAD;
			os_cnt <= '0;
			os_tick <= 1'b0;
			bit_tick <= 1'b0;
		end else begin
			os_tick <= div_zero; // one clock wide, once per UART_OS_DIV clocks
			bit_tick <= div_zero && (os_cnt == PH_LAST); // shares the cycle of every 16th os tick
			if (div_zero) begin
				div_cnt <= DIV_RELOAD;
				os_cnt <= os_cnt + 1'b1; // wraps to zero after PH_LAST
			end else begin
				div_cnt <= div_cnt - 1'b1;
			end
		end
	end

	// the tx and rx blocks both assume a bit tick is also an os tick
	bit_tick_on_os_tick: assert property (@(posedge clk_in) disable iff (!arst_n)
		bit_tick |-> os_tick)
		else $error("bit_tick without os_tick");

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/100ps
`include "uart_defines.svh"

module uart_tx (
	input  logic       clk_in,
	input  logic       arst_n,
	input  logic       bit_tick,
	input  logic       tx_req,
	input  logic [7:0] tx_data,
	output logic       tx,
	output logic       busy,
	output logic       done
);

	localparam int CNT_W = $clog2(`UART_DATA_BITS + 1); // counts 0 to UART_DATA_BITS
	localparam logic [CNT_W-1:0] BIT_END = CNT_W'(`UART_DATA_BITS); // all data bits are out

	uart_pkg::uart_tx_state_t state; // frame position
	logic [7:0] shreg; // captured byte, bit 0 is the next one on the line
	logic [CNT_W-1:0] bit_cnt; // data bits already put on the line

	// control path, everything here moves on bit_tick except the capture in idle
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			state <= uart_pkg::TX_IDLE;
			bit_cnt <= '0;
			tx <= 1'b1; // line idles high
		end else begin
			case (state)
				uart_pkg::TX_IDLE: begin
					if (tx_req) begin // request is a level, sampled only while idle
						state <= uart_pkg::TX_START;
						bit_cnt <= '0;
					end
				end
				uart_pkg::TX_START: begin
					if (bit_tick) begin
						tx <= 1'b0; // start bit
						state <= uart_pkg::TX_DATA;
					end
				end
				uart_pkg::TX_DATA: begin
					if (bit_tick) begin
						if (bit_cnt == BIT_END) begin
							tx <= 1'b1; // last data bit has had its full period, stop bit begins
							state <= uart_pkg::TX_STOP;
						end else begin
							tx <= shreg[0]; // lsb first
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				uart_pkg::TX_STOP: begin
					if (bit_tick) begin
						state <= uart_pkg::TX_IDLE; // stop bit held for one whole bit
					end
				end
				default: begin
					tx <= 1'b1;
					state <= uart_pkg::TX_IDLE;
				end
			endcase
		end
	end

	// payload shifter, loaded on the accepted request and shifted with each data bit
	always_ff @(posedge clk_in) begin
		if (state == uart_pkg::TX_IDLE && tx_req) begin
			shreg <= tx_data;
		end else if (state == uart_pkg::TX_DATA && bit_tick) begin
			shreg <= shreg >> 1;
		end
	end

	assign busy = (state != uart_pkg::TX_IDLE); // rises the cycle after the request is taken
	assign done = (state == uart_pkg::TX_STOP); // falls exactly when busy falls

	// a frame must always leave the line released
	tx_high_when_idle: assert property (@(posedge clk_in) disable iff (!arst_n)
		(state == uart_pkg::TX_IDLE) |-> tx)
		else $error("tx low while idle");

	// the stop bit is on the line for the whole time done is high
	done_within_busy: assert property (@(posedge clk_in) disable iff (!arst_n)
		done |-> (busy && tx))
		else $error("done without busy or a high stop bit");

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/100ps
`include "uart_defines.svh"

module uart_rx (
	input  logic                     clk_in,
	input  logic                     arst_n,
	input  logic                     os_tick,
	input  logic                     rx,
	output logic                     rx_valid,
	output uart_pkg::uart_rx_result_t rx_result
);

	localparam int PH_W = $clog2(`UART_OS_RATE);
	localparam logic [PH_W-1:0] PH_MID = PH_W'(`UART_OS_RATE / 2 - 1); // 8th os tick after the edge
	localparam logic [PH_W-1:0] PH_LAST = PH_W'(`UART_OS_RATE - 1); // 16th os tick, one bit later
	localparam logic [2:0] IDX_LAST = 3'(`UART_DATA_BITS - 1);

	uart_pkg::uart_rx_state_t state;
	logic rx_meta; // first synchronizer stage
	logic rx_sync; // line as seen by the state machine
	logic rx_last; // rx_sync at the previous os tick, for edge detection
	logic [PH_W-1:0] phase; // os ticks since the last sample point
	logic [2:0] bit_idx; // data bit being received
	logic [7:0] shreg; // bits arrive lsb first and move down from the top
	logic bit_point; // this os tick is the middle of a data or stop bit

	assign bit_point = os_tick && (phase == PH_LAST);

	// two-flop synchronizer, the line idles high
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			state <= uart_pkg::RX_IDLE;
			rx_last <= 1'b1;
			phase <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
			rx_result <= '0;
		end else begin
			rx_valid <= 1'b0; // single-cycle pulse
			if (os_tick) begin
				rx_last <= rx_sync; // a low stop bit must rise again before the next start counts
			end
			case (state)
				uart_pkg::RX_IDLE: begin
					if (os_tick && rx_last && !rx_sync) begin // falling edge
						state <= uart_pkg::RX_START;
						phase <= '0;
					end
				end
				uart_pkg::RX_START: begin
					if (os_tick) begin
						if (phase == PH_MID) begin
							phase <= '0;
							bit_idx <= '0;
							// a line that is high again in mid start bit was only a glitch
							state <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
						end else begin
							phase <= phase + 1'b1;
						end
					end
				end
				uart_pkg::RX_DATA: begin
					if (os_tick) begin
						phase <= phase + 1'b1; // wraps to zero at each sample point
					end
					if (bit_point) begin
						if (bit_idx == IDX_LAST) begin
							state <= uart_pkg::RX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				uart_pkg::RX_STOP: begin
					if (os_tick) begin
						phase <= phase + 1'b1;
					end
					if (bit_point) begin
						rx_result.data <= shreg; // overwrites the previous byte, nothing is buffered
						rx_result.frame_err <= !rx_sync; // stop bit must be high
						rx_valid <= 1'b1;
						state <= uart_pkg::RX_IDLE;
					end
				end
				default: begin
					state <= uart_pkg::RX_IDLE;
				end
			endcase
		end
	end

	// payload shifter, one bit per data sample point
	always_ff @(posedge clk_in) begin
		if (state == uart_pkg::RX_DATA && bit_point) begin
			shreg <= {rx_sync, shreg[7:1]};
		end
	end

	// frames are 160 os ticks apart at least, so a pulse can never stretch
	rx_valid_one_cycle: assert property (@(posedge clk_in) disable iff (!arst_n)
		rx_valid |=> !rx_valid)
		else $error("rx_valid high for two cycles");

endmodule

// ==== verilog/uart_top.sv ====
`timescale 1ns/100ps

module uart_top (
	input  logic                      clk_in,
	input  logic                      arst_n,
	input  logic                      tx_req,
	input  logic [7:0]                tx_data,
	output logic                      tx,
	output logic                      tx_busy,
	output logic                      tx_done,
	input  logic                      rx,
	output logic                      rx_valid,
	output uart_pkg::uart_rx_result_t rx_result
);

	logic os_tick; // 16x bit rate strobe, used by the receiver
	logic bit_tick; // bit rate strobe, used by the transmitter

	// one tick source shared by both directions
	baud_tick_gen tick_gen_i (
		.clk_in   (clk_in),
		.arst_n   (arst_n),
		.os_tick  (os_tick),
		.bit_tick (bit_tick)
	);

	uart_tx tx_i (
		.clk_in   (clk_in),
		.arst_n   (arst_n),
		.bit_tick (bit_tick),
		.tx_req   (tx_req),
		.tx_data  (tx_data),
		.tx       (tx),
		.busy     (tx_busy),
		.done     (tx_done)
	);

	// rx aligns to the received start edge, so it only takes the fast tick
	uart_rx rx_i (
		.clk_in    (clk_in),
		.arst_n    (arst_n),
		.os_tick   (os_tick),
		.rx        (rx),
		.rx_valid  (rx_valid),
		.rx_result (rx_result)
	);

endmodule

// ==== test/uart_top_tb.sv ====
`timescale 1ns/100ps
`include "uart_defines.svh"

module uart_top_tb;

	localparam int BIT_CLKS = `UART_OS_DIV * `UART_OS_RATE; // clocks per bit on the line
	localparam int FRAME_CLKS = BIT_CLKS * (`UART_DATA_BITS + 2); // start, data and stop bits
	localparam int ROWS = 9;

	typedef struct packed {
		logic [7:0] data; // byte put on the line
		logic       bitbang; // set when the testbench drives rx itself
		logic       stop_bit; // stop bit level of a bit-banged frame
		logic [7:0] exp_data;
		logic       exp_err;
	} stim_row_t;

	logic clk_in;
	logic arst_n;
	logic tx_req;
	logic [7:0] tx_data;
	logic tx_line; // DUT tx output
	logic tx_busy;
	logic tx_done;
	logic rx_loopback; // selects the DUT's own tx as the rx source
	logic rx_line; // rx level when the testbench drives it
	logic rx_to_dut;
	logic rx_valid;
	uart_pkg::uart_rx_result_t rx_result;
	logic [7:0] lfsr_state;
	uart_pkg::uart_rx_result_t rx_events [$]; // every rx_valid pulse lands here

	stim_row_t stim_table [ROWS] = '{
		'{8'h55, 1'b0, 1'b1, 8'h55, 1'b0}, // alternating bits through loopback
		'{8'hA3, 1'b0, 1'b1, 8'hA3, 1'b0},
		'{8'h00, 1'b0, 1'b1, 8'h00, 1'b0}, // longest low stretch on the line
		'{8'hFF, 1'b0, 1'b1, 8'hFF, 1'b0},
		'{8'h81, 1'b0, 1'b1, 8'h81, 1'b0},
		'{8'h3C, 1'b1, 1'b0, 8'h3C, 1'b1}, // low stop bit flags a framing error
		'{8'hC5, 1'b1, 1'b1, 8'hC5, 1'b0}, // a good frame clears the flag again
		'{8'h0F, 1'b1, 1'b0, 8'h0F, 1'b1},
		'{8'h96, 1'b0, 1'b1, 8'h96, 1'b0}
	};

	assign rx_to_dut = rx_loopback ? tx_line : rx_line;

	uart_top dut_i (
		.clk_in    (clk_in),
		.arst_n    (arst_n),
		.tx_req    (tx_req),
		.tx_data   (tx_data),
		.tx        (tx_line),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx        (rx_to_dut),
		.rx_valid  (rx_valid),
		.rx_result (rx_result)
	);

	always #4 clk_in = ~clk_in; // 8 ns period

	// rx outputs are registered on the rising edge, so the falling edge sees them settled
	always @(negedge clk_in) begin
		if (arst_n && rx_valid) begin
			rx_events.push_back(rx_result);
		end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t ns: %s never came", $time, what);
		$display("Simulation failed");
		$fatal(1, "stopped on a timeout");
	endtask

	// every step ends 1 ns after a rising edge, where inputs change and outputs are read
	task automatic advance_cycles(input int n);
		repeat (n) begin
			@(posedge clk_in);
			#1;
		end
	endtask

	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]}; // x^8 + x^6 + x^5 + x^4 + 1
	endfunction

	task automatic random_byte(output logic [7:0] value);
		int k;
		value = '0;
		for (k = 0; k < 8; k++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit taken
			value[k] = lfsr_state[0];
		end
	endtask

	task automatic wait_tx_idle();
		int cycles;
		cycles = 0;
		while (tx_busy) begin
			if (cycles == 2 * FRAME_CLKS) report_timeout("tx_busy going low");
			advance_cycles(1);
			cycles++;
		end
	endtask

	task automatic wait_rx_result(output uart_pkg::uart_rx_result_t res);
		int cycles;
		cycles = 0;
		while (rx_events.size() == 0) begin
			if (cycles == 2 * FRAME_CLKS) report_timeout("rx_valid");
			advance_cycles(1);
			cycles++;
		end
		res = rx_events.pop_front();
	endtask

	// sends one byte through the DUT and checks the line in the middle of every bit
	task automatic send_from_dut(input logic [7:0] data);
		int k;
		int cycles;
		wait_tx_idle();
		tx_data = data;
		tx_req = 1'b1;
		advance_cycles(1);
		tx_req = 1'b0;
		cycles = 0;
		while (tx_line) begin
			if (cycles == 2 * BIT_CLKS) report_timeout("start edge on tx");
			advance_cycles(1);
			cycles++;
		end
		advance_cycles(BIT_CLKS / 2);
		check_value(32'(tx_line), 32'd0, $sformatf("start bit of %02h", data));
		for (k = 0; k < 8; k++) begin
			advance_cycles(BIT_CLKS);
			check_value(32'(tx_line), 32'(data[k]), $sformatf("tx bit %0d of %02h", k, data));
		end
		advance_cycles(BIT_CLKS);
		check_value(32'(tx_line), 32'd1, $sformatf("stop bit of %02h", data));
		check_value(32'(tx_done), 32'd1, "tx_done during the stop bit");
	endtask

	task automatic bitbang_frame(input logic [7:0] data, input logic stop_bit);
		int k;
		rx_line = 1'b0;
		advance_cycles(BIT_CLKS);
		for (k = 0; k < 8; k++) begin
			rx_line = data[k];
			advance_cycles(BIT_CLKS);
		end
		rx_line = stop_bit;
		advance_cycles(BIT_CLKS);
		rx_line = 1'b1; // idle gap so the receiver sees a fresh falling edge next time
		advance_cycles(BIT_CLKS);
	endtask

	initial begin
		int i;
		int cycles;
		logic prev_done;
		logic [7:0] b;
		stim_row_t row;
		uart_pkg::uart_rx_result_t res;
		clk_in = 1'b0;
		arst_n = 1'b0;
		tx_req = 1'b0;
		tx_data = 8'h00;
		rx_line = 1'b1;
		rx_loopback = 1'b1;
		lfsr_state = 8'd61;
		repeat (5) @(posedge clk_in);
		#1;
		arst_n = 1'b1;
		advance_cycles(2);
		check_value(32'(tx_line), 32'd1, "tx after reset");
		check_value(32'(tx_busy), 32'd0, "tx_busy after reset");
		check_value(32'(tx_done), 32'd0, "tx_done after reset");
		check_value(32'(rx_valid), 32'd0, "rx_valid after reset");
		check_value(32'(rx_result), 32'd0, "rx_result after reset");

		for (i = 0; i < ROWS; i++) begin
			row = stim_table[i];
			rx_loopback = !row.bitbang;
			if (row.bitbang) begin
				bitbang_frame(row.data, row.stop_bit);
			end else begin
				send_from_dut(row.data);
			end
			wait_rx_result(res);
			check_value(32'(res.data), 32'(row.exp_data), $sformatf("rx data, row %0d", i));
			check_value(32'(res.frame_err), 32'(row.exp_err), $sformatf("frame_err, row %0d", i));
		end

		rx_loopback = 1'b1;
		for (i = 0; i < 16; i++) begin
			random_byte(b);
			send_from_dut(b);
			wait_rx_result(res);
			check_value(32'(res.data), 32'(b), "rx data of a random byte");
			check_value(32'(res.frame_err), 32'd0, "frame_err of a random byte");
		end

		// a second request while busy must be dropped
		wait_tx_idle();
		tx_data = 8'hA5;
		tx_req = 1'b1;
		advance_cycles(1);
		tx_req = 1'b0;
		check_value(32'(tx_busy), 32'd1, "tx_busy after a request");
		advance_cycles(BIT_CLKS);
		tx_data = 8'h5A;
		tx_req = 1'b1;
		advance_cycles(1);
		tx_req = 1'b0;
		prev_done = 1'b0;
		cycles = 0;
		while (!(prev_done && !tx_done)) begin
			if (cycles == 2 * FRAME_CLKS) report_timeout("falling edge of tx_done");
			check_value(32'(tx_busy), 32'd1, "tx_busy during the frame");
			prev_done = tx_done;
			advance_cycles(1);
			cycles++;
		end
		check_value(32'(tx_busy), 32'd0, "tx_busy after tx_done fell");
		wait_rx_result(res);
		check_value(32'(res.data), 32'hA5, "byte received under back-pressure");
		for (i = 0; i < FRAME_CLKS; i++) begin
			check_value(32'(tx_line), 32'd1, "tx after the dropped request");
			check_value(32'(tx_busy), 32'd0, "tx_busy after the dropped request");
			advance_cycles(1);
		end
		check_value(32'(rx_events.size()), 32'd0, "extra frame after the dropped request");

		// a short low pulse is shorter than half a bit and must not start a frame
		rx_loopback = 1'b0;
		rx_line = 1'b0;
		advance_cycles(8);
		rx_line = 1'b1;
		advance_cycles(FRAME_CLKS + BIT_CLKS);
		check_value(32'(rx_events.size()), 32'd0, "rx_valid after a glitch");

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== uart_top.f ====
+incdir+verilog
verilog/uart_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_top.sv
test/uart_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the UART testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f uart_top.f --top-module uart_top_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vuart_top_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation run returned status $sim_status"
	exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
